/* verilog/cam_sensor_pkg.sv */
// Camera sensor side definitions for the OV7670 capture path
package cam_sensor_pkg;

    // Frame geometry as seen by the capture logic
    localparam int FRAME_LINES   = 120;
    localparam int FRAME_COLUMNS = 320;
    localparam int LINE_W        = 7;
    localparam int COLUMN_W      = 9;

    // System clocks per xclk half period
    localparam int XCLK_HALF_PERIOD = 25;
    localparam int XCLK_DIV_W       = 5;

    // RGB565 pixel word, high byte arrives first
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } pixel_t;

    // Raw pins coming from the sensor
    typedef struct packed {
        logic       vsync;
        logic       pclk;
        logic [7:0] d;
    } sensor_bus_t;

    typedef struct packed {
        logic [LINE_W-1:0]   line;
        logic [COLUMN_W-1:0] column;
    } pixel_pos_t;

    // Strobes from the control unit into the datapath
    typedef struct packed {
        logic clear_pos;
        logic count_column;
        logic count_line;
        logic clear_grid_col;
        logic count_grid_col;
        logic clear_grid_row;
        logic count_grid_row;
        logic latch_high;
        logic latch_low;
        logic write_sample;
    } fd_ctrl_t;

    // Status flags returned by the datapath
    typedef struct packed {
        logic frame_start;
        logic byte_edge;
        logic column_end;
        logic line_end;
        logic sample_hit;
        logic grid_col_end;
    } fd_status_t;

endpackage

/* verilog/sample_grid_pkg.sv */
// Sample grid definitions for the 3 by 3 pixel sample memory
package sample_grid_pkg;

    localparam int GRID_ROWS   = 3;
    localparam int GRID_COLS   = 3;
    localparam int GRID_ADDR_W = 2;

    // Frame positions that get sampled
    localparam int SAMPLE_LINES [GRID_ROWS] = '{20, 60, 100};
    localparam int SAMPLE_COLUMNS [GRID_COLS] = '{79, 159, 239};

    // Cell address in the sample memory
    typedef struct packed {
        logic [GRID_ADDR_W-1:0] row;
        logic [GRID_ADDR_W-1:0] col;
    } grid_addr_t;

endpackage

/* verilog/sync_edge_detector.sv */
// Synchronizes an asynchronous input and flags each rising edge with a registered pulse
`timescale 1ns/100ps

module sync_edge_detector (
    input  logic clock,
    input  logic rst_n,
    input  logic sig,
    output logic pulse
);

    logic sync_0;
    logic sync_1;
    logic sync_prev;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            sync_0    <= 1'b0;
            sync_1    <= 1'b0;
            sync_prev <= 1'b0;
            pulse     <= 1'b0;
        end else begin
            sync_0    <= sig;
            sync_1    <= sync_0;
            sync_prev <= sync_1;
            // Edge register, high for one cycle only
            pulse     <= sync_1 & ~sync_prev;
        end
    end

    assert property (@(posedge clock) disable iff (!rst_n) pulse |=> !pulse)
        else $error("sync_edge_detector: pulse held for two cycles");

endmodule

/* verilog/mod_counter.sv */
// Modulo-M counter with synchronous clear, count enable and terminal count flag
`timescale 1ns/100ps

module mod_counter #(
    parameter int M = 16,
    parameter int N = 4
) (
    input  logic         clock,
    input  logic         rst_n,
    input  logic         clear,
    input  logic         count,
    output logic [N-1:0] q,
    output logic         last
);

    assign last = (q == N'(M - 1));

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            q <= '0;
        end else if (clear) begin
            q <= '0;
        end else if (count) begin
            // Wrap back to zero after M-1
            q <= last ? '0 : q + 1'b1;
        end
    end

    assert property (@(posedge clock) disable iff (!rst_n) int'(q) < M)
        else $error("mod_counter: q left the range 0..M-1");

endmodule

/* verilog/sample_ram.sv */
// Nine word sample memory with one write port and a registered read port
`timescale 1ns/100ps

module sample_ram (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        we,
    input  sample_grid_pkg::grid_addr_t wr_addr,
    input  cam_sensor_pkg::pixel_t      wr_data,
    input  sample_grid_pkg::grid_addr_t rd_addr,
    output cam_sensor_pkg::pixel_t      rd_data
);

    cam_sensor_pkg::pixel_t mem [sample_grid_pkg::GRID_ROWS][sample_grid_pkg::GRID_COLS];

    // Contents start from zero so unwritten cells read back clean
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int r = 0; r < sample_grid_pkg::GRID_ROWS; r++) begin
                for (int c = 0; c < sample_grid_pkg::GRID_COLS; c++) begin
                    mem[r][c] <= '0;
                end
            end
        end else if (we) begin
            mem[wr_addr.row][wr_addr.col] <= wr_data;
        end
    end

    // Read data one cycle after the address
    always_ff @(posedge clock) begin
        rd_data <= mem[rd_addr.row][rd_addr.col];
    end

    assert property (@(posedge clock) disable iff (!rst_n)
        we |-> (int'(wr_addr.row) < sample_grid_pkg::GRID_ROWS
                && int'(wr_addr.col) < sample_grid_pkg::GRID_COLS))
        else $error("sample_ram: write outside the sample grid");

endmodule

/* verilog/ov7670_capture_fd.sv */
// OV7670 capture datapath with input sync, position and grid counters, sample store and xclk
`timescale 1ns/100ps

module ov7670_capture_fd (
    input  logic                        clock,
    input  logic                        rst_n,
    input  cam_sensor_pkg::sensor_bus_t sensor,
    input  cam_sensor_pkg::fd_ctrl_t    ctrl,
    output cam_sensor_pkg::fd_status_t  status,
    output logic                        xclk,
    input  sample_grid_pkg::grid_addr_t rd_addr,
    output cam_sensor_pkg::pixel_t      rd_pixel
);

    cam_sensor_pkg::pixel_pos_t              pos;
    logic [cam_sensor_pkg::LINE_W-1:0]       line_q;
    logic [cam_sensor_pkg::COLUMN_W-1:0]     column_q;
    sample_grid_pkg::grid_addr_t             wr_addr;
    logic [sample_grid_pkg::GRID_ADDR_W-1:0] grid_row;
    logic [sample_grid_pkg::GRID_ADDR_W-1:0] grid_col;
    logic [15:0]                             byte_pair;
    logic                                    frame_start;
    logic                                    byte_edge;
    logic                                    column_end;
    logic                                    line_end;
    logic                                    grid_col_end;
    logic                                    line_hit;
    logic                                    column_hit;
    logic                                    xclk_toggle;

    // Frame begins when vsync falls
    sync_edge_detector frame_edge (
        .clock (clock),
        .rst_n (rst_n),
        .sig   (~sensor.vsync),
        .pulse (frame_start)
    );

    sync_edge_detector byte_edge_det (
        .clock (clock),
        .rst_n (rst_n),
        .sig   (sensor.pclk),
        .pulse (byte_edge)
    );

    mod_counter #(
        .M (cam_sensor_pkg::FRAME_COLUMNS),
        .N (cam_sensor_pkg::COLUMN_W)
    ) column_counter (
        .clock (clock),
        .rst_n (rst_n),
        .clear (ctrl.clear_pos),
        .count (ctrl.count_column),
        .q     (column_q),
        .last  (column_end)
    );

    mod_counter #(
        .M (cam_sensor_pkg::FRAME_LINES),
        .N (cam_sensor_pkg::LINE_W)
    ) line_counter (
        .clock (clock),
        .rst_n (rst_n),
        .clear (ctrl.clear_pos),
        .count (ctrl.count_line),
        .q     (line_q),
        .last  (line_end)
    );

    assign pos = '{line: line_q, column: column_q};

    // Sample position match against the grid tables
    always_comb begin
        line_hit   = 1'b0;
        column_hit = 1'b0;
        for (int i = 0; i < sample_grid_pkg::GRID_ROWS; i++) begin
            if (int'(pos.line) == sample_grid_pkg::SAMPLE_LINES[i]) begin
                line_hit = 1'b1;
            end
        end
        for (int j = 0; j < sample_grid_pkg::GRID_COLS; j++) begin
            if (int'(pos.column) == sample_grid_pkg::SAMPLE_COLUMNS[j]) begin
                column_hit = 1'b1;
            end
        end
    end

    mod_counter #(
        .M (sample_grid_pkg::GRID_COLS),
        .N (sample_grid_pkg::GRID_ADDR_W)
    ) grid_col_counter (
        .clock (clock),
        .rst_n (rst_n),
        .clear (ctrl.clear_grid_col),
        .count (ctrl.count_grid_col),
        .q     (grid_col),
        .last  (grid_col_end)
    );

    mod_counter #(
        .M (sample_grid_pkg::GRID_ROWS),
        .N (sample_grid_pkg::GRID_ADDR_W)
    ) grid_row_counter (
        .clock (clock),
        .rst_n (rst_n),
        .clear (ctrl.clear_grid_row),
        .count (ctrl.count_grid_row),
        .q     (grid_row),
        .last  ()
    );

    assign wr_addr = '{row: grid_row, col: grid_col};

    assign status = '{
        frame_start:  frame_start,
        byte_edge:    byte_edge,
        column_end:   column_end,
        line_end:     line_end,
        sample_hit:   line_hit & column_hit,
        grid_col_end: grid_col_end
    };

    // Byte pair, high byte first
    always_ff @(posedge clock) begin
        if (ctrl.latch_high) begin
            byte_pair[15:8] <= sensor.d;
        end
        if (ctrl.latch_low) begin
            byte_pair[7:0] <= sensor.d;
        end
    end

    sample_ram sample_mem (
        .clock   (clock),
        .rst_n   (rst_n),
        .we      (ctrl.write_sample),
        .wr_addr (wr_addr),
        .wr_data (cam_sensor_pkg::pixel_t'(byte_pair)),
        .rd_addr (rd_addr),
        .rd_data (rd_pixel)
    );

    // Master clock divider for the sensor
    mod_counter #(
        .M (cam_sensor_pkg::XCLK_HALF_PERIOD),
        .N (cam_sensor_pkg::XCLK_DIV_W)
    ) xclk_divider (
        .clock (clock),
        .rst_n (rst_n),
        .clear (1'b0),
        .count (1'b1),
        .q     (),
        .last  (xclk_toggle)
    );

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            xclk <= 1'b0;
        end else if (xclk_toggle) begin
            xclk <= ~xclk;
        end
    end

endmodule

/* verilog/ov7670_capture_uc.sv */
// OV7670 capture control FSM sequencing bytes, pixel position and sample grid
`timescale 1ns/100ps

module ov7670_capture_uc (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       capture_en,
    input  cam_sensor_pkg::fd_status_t status,
    output cam_sensor_pkg::fd_ctrl_t   ctrl,
    output logic                       frame_done
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_HIGH,
        WAIT_LOW,
        DONE
    } state_t;

    state_t state;
    state_t state_next;
    logic   low_latched;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state       <= IDLE;
            low_latched <= 1'b0;
        end else begin
            state       <= state_next;
            // Pixel is complete the cycle after its low byte
            low_latched <= ctrl.latch_low;
        end
    end

    always_comb begin
        state_next = state;
        ctrl       = '0;
        frame_done = 1'b0;
        case (state)
            IDLE: begin
                if (capture_en && status.frame_start) begin
                    ctrl.clear_pos      = 1'b1;
                    ctrl.clear_grid_col = 1'b1;
                    ctrl.clear_grid_row = 1'b1;
                    state_next          = WAIT_HIGH;
                end
            end
            WAIT_HIGH: begin
                if (status.byte_edge) begin
                    ctrl.latch_high = 1'b1;
                    state_next      = WAIT_LOW;
                end
            end
            WAIT_LOW: begin
                if (low_latched) begin
                    ctrl.count_column   = 1'b1;
                    ctrl.count_line     = status.column_end;
                    ctrl.write_sample   = status.sample_hit;
                    ctrl.count_grid_col = status.sample_hit;
                    // Next grid row once the third cell of a row is written
                    ctrl.count_grid_row = status.sample_hit & status.grid_col_end;
                    if (status.column_end && status.line_end) begin
                        state_next = DONE;
                    end else begin
                        state_next = WAIT_HIGH;
                    end
                end else if (status.byte_edge) begin
                    ctrl.latch_low = 1'b1;
                end
            end
            DONE: begin
                frame_done = 1'b1;
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // A sample write always follows a low byte latch by one cycle
    assert property (@(posedge clock) disable iff (!rst_n)
        ctrl.write_sample |-> (state == WAIT_LOW && $past(ctrl.latch_low)))
        else $error("ov7670_capture_uc: sample write outside the low byte phase");

endmodule

/* verilog/ov7670_capture.sv */
// OV7670 capture top level joining the control FSM and the datapath
`timescale 1ns/100ps

module ov7670_capture (
    input  logic                        clock,
    input  logic                        rst_n,
    input  cam_sensor_pkg::sensor_bus_t sensor,
    input  logic                        capture_en,
    output logic                        xclk,
    output logic                        frame_done,
    input  sample_grid_pkg::grid_addr_t rd_addr,
    output cam_sensor_pkg::pixel_t      rd_pixel
);

    cam_sensor_pkg::fd_ctrl_t   ctrl;
    cam_sensor_pkg::fd_status_t status;

    ov7670_capture_uc uc (
        .clock      (clock),
        .rst_n      (rst_n),
        .capture_en (capture_en),
        .status     (status),
        .ctrl       (ctrl),
        .frame_done (frame_done)
    );

    ov7670_capture_fd fd (
        .clock    (clock),
        .rst_n    (rst_n),
        .sensor   (sensor),
        .ctrl     (ctrl),
        .status   (status),
        .xclk     (xclk),
        .rd_addr  (rd_addr),
        .rd_pixel (rd_pixel)
    );

endmodule

/* verification/ov7670_sensor_model.sv */
// Behavioral OV7670 sensor that sends one frame of position coded pixels per start pulse
`timescale 1ns/100ps

module ov7670_sensor_model #(
    parameter int PCLK_HALF    = 5,
    parameter int BLANK_CYCLES = 20
) (
    input  logic                        clock,
    input  logic                        start,
    input  logic [15:0]                 key,
    output cam_sensor_pkg::sensor_bus_t sensor,
    output logic                        busy
);

    logic       vsync   = 1'b0;
    logic       pclk    = 1'b0;
    logic [7:0] d       = 8'h00;
    logic       sending = 1'b0;

    assign sensor = '{vsync: vsync, pclk: pclk, d: d};
    assign busy   = sending;

    // Data changes while pclk is low and holds through the rising edge
    task automatic send_byte(input logic [7:0] value);
        pclk <= 1'b0;
        d    <= value;
        repeat (PCLK_HALF) @(posedge clock);
        pclk <= 1'b1;
        repeat (PCLK_HALF) @(posedge clock);
    endtask

    task automatic send_frame(input logic [15:0] frame_key);
        logic [15:0] pixel;
        sending <= 1'b1;
        vsync   <= 1'b1;
        repeat (BLANK_CYCLES) @(posedge clock);
        // Falling vsync marks the frame start
        vsync <= 1'b0;
        repeat (BLANK_CYCLES) @(posedge clock);
        for (int line = 0; line < cam_sensor_pkg::FRAME_LINES; line++) begin
            for (int column = 0; column < cam_sensor_pkg::FRAME_COLUMNS; column++) begin
                // Pixel word is the line and column packed together
                pixel = {line[6:0], column[8:0]} ^ frame_key;
                send_byte(pixel[15:8]);
                send_byte(pixel[7:0]);
            end
        end
        pclk    <= 1'b0;
        sending <= 1'b0;
    endtask

    always @(posedge clock) begin
        if (start) begin
            send_frame(key);
        end
    end

endmodule

/* verification/tb_ov7670_capture.sv */
// Testbench for the OV7670 capture path driven by a frame table and a sensor model
`timescale 1ns/100ps

module tb_ov7670_capture;

    localparam int CLK_PERIOD      = 8;
    localparam int PCLK_PERIOD     = 10;
    localparam int BLANK_CYCLES    = 20;
    localparam int XCLK_PERIOD     = 2 * cam_sensor_pkg::XCLK_HALF_PERIOD;
    localparam int FRAME_CYCLES    = 2 * BLANK_CYCLES
        + cam_sensor_pkg::FRAME_LINES * cam_sensor_pkg::FRAME_COLUMNS * 2 * PCLK_PERIOD;
    localparam int DRAIN_CYCLES    = 40;
    localparam int NUM_FRAMES      = 3;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * FRAME_CYCLES + 10000;

    typedef struct packed {
        logic [15:0] key;
        logic        random_key;
        logic        capture_en;
        logic        expect_done;
        logic        expect_change;
    } frame_test_t;

    // Key, random key, capture_en, frame_done expected, memory expected to change
    localparam frame_test_t FRAME_TESTS [NUM_FRAMES] = '{
        '{16'h0000, 1'b0, 1'b1, 1'b1, 1'b1},
        '{16'h5a5a, 1'b0, 1'b0, 1'b0, 1'b0},
        '{16'h0000, 1'b1, 1'b1, 1'b1, 1'b1}
    };

    logic                        clock = 1'b0;
    logic                        rst_n;
    logic                        capture_en;
    cam_sensor_pkg::sensor_bus_t sensor;
    logic                        xclk;
    logic                        frame_done;
    sample_grid_pkg::grid_addr_t rd_addr;
    cam_sensor_pkg::pixel_t      rd_pixel;
    logic                        model_start;
    logic [15:0]                 model_key;
    logic                        model_busy;

    int          error_count  = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          done_count   = 0;
    logic [15:0] expected_mem [sample_grid_pkg::GRID_ROWS][sample_grid_pkg::GRID_COLS];

    always #(CLK_PERIOD / 2) clock = ~clock;

    ov7670_capture ov7670_capture_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .sensor     (sensor),
        .capture_en (capture_en),
        .xclk       (xclk),
        .frame_done (frame_done),
        .rd_addr    (rd_addr),
        .rd_pixel   (rd_pixel)
    );

    ov7670_sensor_model #(
        .PCLK_HALF    (PCLK_PERIOD / 2),
        .BLANK_CYCLES (BLANK_CYCLES)
    ) sensor_model (
        .clock  (clock),
        .start  (model_start),
        .key    (model_key),
        .sensor (sensor),
        .busy   (model_busy)
    );

    always @(posedge clock) begin
        if (rst_n && frame_done) begin
            done_count <= done_count + 1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %0d %s: PASS", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL", tests_run, name);
        end
    endtask

    // Pattern the sensor sends at a given frame position
    function automatic logic [15:0] expected_pixel(input int line, input int column,
                                                   input logic [15:0] frame_key);
        logic [15:0] position;
        position = {line[6:0], column[8:0]};
        return position ^ frame_key;
    endfunction

    task automatic read_cell(input int row, input int col, output logic [15:0] value);
        sample_grid_pkg::grid_addr_t addr;
        addr.row = 2'(row);
        addr.col = 2'(col);
        @(posedge clock);
        rd_addr <= addr;
        @(posedge clock);
        @(negedge clock);
        value = rd_pixel;
    endtask

    task automatic check_all_cells();
        logic [15:0] value;
        for (int r = 0; r < sample_grid_pkg::GRID_ROWS; r++) begin
            for (int c = 0; c < sample_grid_pkg::GRID_COLS; c++) begin
                read_cell(r, c, value);
                check_value($sformatf("rd_pixel[%0d][%0d]", r, c),
                            32'(expected_mem[r][c]), 32'(value));
            end
        end
    endtask

    // Counts clock cycles between two rising edges of xclk
    task automatic measure_xclk_period(output int period);
        int   cycles;
        int   rises;
        logic prev;
        cycles = 0;
        rises  = 0;
        period = 0;
        @(negedge clock);
        prev = xclk;
        while (rises < 2 && cycles < 4 * XCLK_PERIOD) begin
            @(negedge clock);
            cycles++;
            if (!prev && xclk) begin
                rises++;
                if (rises == 1) begin
                    cycles = 0;
                end else begin
                    period = cycles;
                end
            end
            prev = xclk;
        end
    endtask

    task automatic run_frame(input frame_test_t test);
        logic [15:0] frame_key;
        int          done_before;
        int          errors_before;
        int          cycles;
        int          idle_cycles;
        errors_before = error_count;
        done_before   = done_count;
        frame_key     = test.random_key ? 16'($urandom) : test.key;
        @(posedge clock);
        capture_en  <= test.capture_en;
        model_key   <= frame_key;
        model_start <= 1'b1;
        @(posedge clock);
        model_start <= 1'b0;
        cycles      = 0;
        idle_cycles = 0;
        // Ends on frame_done, or once the sensor has gone quiet without one
        while (done_count == done_before && idle_cycles < DRAIN_CYCLES
               && cycles < FRAME_CYCLES + DRAIN_CYCLES) begin
            @(negedge clock);
            cycles++;
            if (!model_busy) begin
                idle_cycles++;
            end
        end
        if (done_count == done_before && idle_cycles < DRAIN_CYCLES) begin
            $display("ERROR at %0t: frame did not end within %0d cycles", $time, cycles);
            error_count++;
        end
        check_value("frame_done count", 32'(test.expect_done), 32'(done_count - done_before));
        if (test.expect_change) begin
            for (int r = 0; r < sample_grid_pkg::GRID_ROWS; r++) begin
                for (int c = 0; c < sample_grid_pkg::GRID_COLS; c++) begin
                    expected_mem[r][c] = expected_pixel(sample_grid_pkg::SAMPLE_LINES[r],
                                                        sample_grid_pkg::SAMPLE_COLUMNS[c],
                                                        frame_key);
                end
            end
        end
        check_all_cells();
        report_test($sformatf("frame key %h capture_en %b", frame_key, test.capture_en),
                    errors_before);
    endtask

    initial begin
        int errors_before;
        int period;
        rst_n       = 1'b0;
        capture_en  = 1'b0;
        rd_addr     = '0;
        model_start = 1'b0;
        model_key   = 16'h0000;
        void'($urandom(32'h70f67ccb));
        for (int r = 0; r < sample_grid_pkg::GRID_ROWS; r++) begin
            for (int c = 0; c < sample_grid_pkg::GRID_COLS; c++) begin
                expected_mem[r][c] = 16'h0000;
            end
        end
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;

        // State straight after reset
        errors_before = error_count;
        @(negedge clock);
        check_value("xclk", 32'(1'b0), 32'(xclk));
        check_value("frame_done", 32'(1'b0), 32'(frame_done));
        check_all_cells();
        report_test("reset state", errors_before);

        errors_before = error_count;
        measure_xclk_period(period);
        check_value("xclk period", 32'(XCLK_PERIOD), 32'(period));
        report_test("xclk period", errors_before);

        for (int i = 0; i < NUM_FRAMES; i++) begin
            run_frame(FRAME_TESTS[i]);
        end

        $display("summary: run %0d, passed %0d, failed %0d, check errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog timeout after %0d clock cycles, the run did not finish",
                 WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule

/* filelist.f */
verilog/cam_sensor_pkg.sv
verilog/sample_grid_pkg.sv
verilog/sync_edge_detector.sv
verilog/mod_counter.sv
verilog/sample_ram.sv
verilog/ov7670_capture_fd.sv
verilog/ov7670_capture_uc.sv
verilog/ov7670_capture.sv
verification/ov7670_sensor_model.sv
verification/tb_ov7670_capture.sv

/* Makefile */
# Verilator build and run for the OV7670 capture testbench

VERILATOR       ?= verilator
TOP             ?= tb_ov7670_capture
FILELIST        ?= filelist.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
FAIL_MSG        ?= tests failed
VERILATOR_FLAGS ?= --binary --timing --timescale 1ns/100ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation finished without failures"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
